//--- verilog/dds_pkg.sv
`default_nettype none

package dds_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------

  // Phase is an unsigned fraction of one turn
  localparam int PHASE_W    = 24;
  // Output word is {Q, I}
  localparam int IQ_W       = 32;
  // Each component is signed Q2.14
  localparam int SAMPLE_W   = 16;
  // Index into one quarter of the sine table
  localparam int QUAD_IDX_W = 8;
  // Burst length
  localparam int COUNT_W    = 16;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------

  typedef logic        [PHASE_W-1:0]  phase_t;
  typedef logic        [IQ_W-1:0]     iq_t;
  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [COUNT_W-1:0]  count_t;

  // Burst generator FSM
  typedef enum logic {
    IDLE,
    RUN
  } burst_state_t;

endpackage

`default_nettype wire

//--- verilog/stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Valid/ready stream with last and a one-bit sideband
interface stream_if #(
  parameter int DATA_W = 32
);

  logic [DATA_W-1:0] data;
  logic              valid;
  logic              ready;
  logic              last;
  logic              user;

  // Producer side
  modport source (
    output data, valid, last, user,
    input  ready
  );

  // Consumer side
  modport sink (
    input  data, valid, last, user,
    output ready
  );

endinterface

`default_nettype wire

//--- verilog/phase_burst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module phase_burst_gen (
  input  logic            clk,
  input  logic            rst,
  input  dds_pkg::phase_t freq_word,
  input  dds_pkg::count_t num_samples,
  input  logic            start,
  output logic            busy,
  stream_if.source        phase_out
);
  import dds_pkg::*;

  burst_state_t state;
  phase_t       phase_acc;
  phase_t       freq_q;
  count_t       remaining;
  logic         beat_fire;
  logic         final_beat;

  assign beat_fire  = phase_out.valid && phase_out.ready;
  assign final_beat = (remaining == count_t'(1));

  // ----------------------------------------------------------
  // Burst FSM
  // ----------------------------------------------------------

  // Start is only looked at in IDLE, so a pulse mid-burst does nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (start) state <= RUN;
        RUN:     if (beat_fire && final_beat) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Accumulator and sample counter
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      freq_q    <= freq_word;
      phase_acc <= '0;
      // Zero length runs as a single sample
      remaining <= (num_samples == '0) ? count_t'(1) : num_samples;
    end else if (beat_fire) begin
      // Wraps modulo one turn
      phase_acc <= phase_acc + freq_q;
      remaining <= remaining - count_t'(1);
    end
  end

  assign busy            = (state == RUN);
  assign phase_out.valid = (state == RUN);
  assign phase_out.data  = phase_acc;
  assign phase_out.last  = (state == RUN) && final_beat;
  assign phase_out.user  = 1'b0;

  // Held beat keeps its phase until taken
  a_hold_phase: assert property (@(posedge clk) disable iff (rst)
    phase_out.valid && !phase_out.ready |=> phase_out.valid && $stable(phase_out.data));

endmodule

`default_nettype wire

//--- verilog/sincos_lut_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module sincos_lut_pipe #(
  parameter int LUT_LAT = 4
) (
  input  logic     clk,
  input  logic     rst,
  stream_if.sink   phase_in,
  stream_if.source iq_out
);
  import dds_pkg::*;

  localparam int  LUT_SIZE = (1 << QUAD_IDX_W) + 1;
  localparam real HALF_PI  = 1.5707963267948966;
  // Mirror point of the quarter table
  localparam logic [QUAD_IDX_W:0] IDX_FULL = 1 << QUAD_IDX_W;

  // ----------------------------------------------------------
  // Quarter-wave sine table
  // ----------------------------------------------------------

  sample_t sine_lut [0:LUT_SIZE-1];

  // Values are never negative, so adding one half rounds
  initial begin
    for (int i = 0; i < LUT_SIZE; i++) begin
      sine_lut[i] = sample_t'($rtoi(16384.0 * $sin(HALF_PI * i / 256.0) + 0.5));
    end
  end

  // ----------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------

  logic [1:0]            quad;
  logic [QUAD_IDX_W-1:0] idx;
  logic [QUAD_IDX_W:0]   idx_fwd;
  logic [QUAD_IDX_W:0]   idx_rev;
  sample_t               sin_mag;
  sample_t               cos_mag;
  sample_t               sin_val;
  sample_t               cos_val;
  iq_t                   lut_iq;

  // Top 10 bits of the phase: quadrant then index
  assign quad    = phase_in.data[PHASE_W-1 -: 2];
  assign idx     = phase_in.data[PHASE_W-3 -: QUAD_IDX_W];
  assign idx_fwd = {1'b0, idx};
  assign idx_rev = IDX_FULL - idx_fwd;

  // Odd quadrants read the table backwards
  assign sin_mag = quad[0] ? sine_lut[idx_rev] : sine_lut[idx_fwd];
  assign cos_mag = quad[0] ? sine_lut[idx_fwd] : sine_lut[idx_rev];

  // Sine negative in Q2/Q3, cosine in Q1/Q2
  assign sin_val = quad[1] ? -sin_mag : sin_mag;
  assign cos_val = (quad[1] ^ quad[0]) ? -cos_mag : cos_mag;
  assign lut_iq  = {sin_val, cos_val};

  // ----------------------------------------------------------
  // Shift chain and output slot
  // ----------------------------------------------------------

  iq_t                chain_data [LUT_LAT];
  logic [LUT_LAT-1:0] chain_valid;
  logic [LUT_LAT-1:0] chain_last;
  logic [LUT_LAT-1:0] chain_user;
  iq_t                slot_data;
  logic               slot_valid;
  logic               slot_last;
  logic               slot_user;
  logic               in_fire;
  logic               out_fire;

  // Input is taken only when the slot can accept the chain's tail
  assign phase_in.ready = !slot_valid || iq_out.ready;
  assign in_fire        = phase_in.valid && phase_in.ready;
  assign out_fire       = slot_valid && iq_out.ready;

  // Payload moves only on an accepted input beat
  always_ff @(posedge clk) begin
    if (in_fire) begin
      chain_data[0] <= lut_iq;
      for (int s = 1; s < LUT_LAT; s++) begin
        chain_data[s] <= chain_data[s-1];
      end
      chain_last <= {chain_last[LUT_LAT-2:0], phase_in.last};
      chain_user <= {chain_user[LUT_LAT-2:0], phase_in.user};
      slot_data  <= chain_data[LUT_LAT-1];
      slot_last  <= chain_last[LUT_LAT-1];
      slot_user  <= chain_user[LUT_LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chain_valid <= '0;
      slot_valid  <= 1'b0;
    end else if (in_fire) begin
      chain_valid <= {chain_valid[LUT_LAT-2:0], 1'b1};
      slot_valid  <= chain_valid[LUT_LAT-1];
    end else if (out_fire) begin
      slot_valid <= 1'b0;
    end
  end

  assign iq_out.data  = slot_data;
  assign iq_out.valid = slot_valid;
  assign iq_out.last  = slot_last;
  assign iq_out.user  = slot_user;

  // Untaken sample stays put
  a_slot_hold: assert property (@(posedge clk) disable iff (rst)
    slot_valid && !iq_out.ready |=> slot_valid && $stable(slot_data));

endmodule

`default_nettype wire

//--- verilog/dds_flush_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module dds_flush_wrapper #(
  parameter int LUT_LAT = 4
) (
  input  logic         clk,
  input  logic         rst,
  stream_if.sink       phase_in,
  stream_if.source     core_in,
  stream_if.sink       core_out,
  output dds_pkg::iq_t iq_data,
  output logic         iq_valid,
  output logic         iq_last,
  input  logic         iq_ready
);

  // Core holds at most LUT_LAT in the chain plus one in its slot
  localparam int FULL_W = $clog2(LUT_LAT + 2);

  // ----------------------------------------------------------
  // Fullness counter
  // ----------------------------------------------------------

  logic [FULL_W-1:0] fullness;
  logic              has_data;
  logic              incr;
  logic              decr;

  // Flush beats never touch the count
  assign incr = phase_in.valid && phase_in.ready;
  assign decr = iq_valid && iq_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      fullness <= '0;
      has_data <= 1'b0;
    end else if (incr && !decr) begin
      fullness <= fullness + 1'b1;
      has_data <= 1'b1;
    end else if (decr && !incr) begin
      fullness <= fullness - 1'b1;
      has_data <= (fullness > 1);
    end else begin
      has_data <= (fullness != '0);
    end
  end

  // ----------------------------------------------------------
  // Core input
  // ----------------------------------------------------------

  assign phase_in.ready = core_in.ready;
  assign core_in.data   = phase_in.data;
  assign core_in.last   = phase_in.last;

  // Keep feeding the core while anything real is stuck in it
  assign core_in.valid  = phase_in.valid || has_data;
  // A beat with no real phase behind it is a flush
  assign core_in.user   = !phase_in.valid;

  // ----------------------------------------------------------
  // Core output
  // ----------------------------------------------------------

  assign iq_data  = core_out.data;
  // Last only shows together with a real sample
  assign iq_last  = core_out.last && iq_valid;

  // Flush results are hidden and drained at once
  assign iq_valid      = core_out.valid && !core_out.user;
  assign core_out.ready = iq_ready || core_out.user;

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    incr && !decr |-> !(&fullness));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    decr && !incr |-> (|fullness));

endmodule

`default_nettype wire

//--- verilog/nco_top.sv
`timescale 1ns/1ps
`default_nettype none

module nco_top #(
  parameter int LUT_LAT = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  dds_pkg::phase_t freq_word,
  input  dds_pkg::count_t num_samples,
  input  logic            start,
  output logic            busy,
  output dds_pkg::iq_t    iq_data,
  output logic            iq_valid,
  output logic            iq_last,
  input  logic            iq_ready
);
  import dds_pkg::*;

  // ----------------------------------------------------------
  // Internal streams
  // ----------------------------------------------------------

  // Burst generator to wrapper
  stream_if #(.DATA_W(PHASE_W)) phase_s ();
  // Wrapper to lookup core, user marks flush beats
  stream_if #(.DATA_W(PHASE_W)) core_in ();
  // Lookup core back to wrapper
  stream_if #(.DATA_W(IQ_W))    core_out ();

  // ----------------------------------------------------------
  // Stages
  // ----------------------------------------------------------

  phase_burst_gen u_burst (
    .clk         (clk),
    .rst         (rst),
    .freq_word   (freq_word),
    .num_samples (num_samples),
    .start       (start),
    .busy        (busy),
    .phase_out   (phase_s)
  );

  dds_flush_wrapper #(.LUT_LAT(LUT_LAT)) u_flush (
    .clk      (clk),
    .rst      (rst),
    .phase_in (phase_s),
    .core_in  (core_in),
    .core_out (core_out),
    .iq_data  (iq_data),
    .iq_valid (iq_valid),
    .iq_last  (iq_last),
    .iq_ready (iq_ready)
  );

  sincos_lut_pipe #(.LUT_LAT(LUT_LAT)) u_lut (
    .clk      (clk),
    .rst      (rst),
    .phase_in (core_in),
    .iq_out   (core_out)
  );

endmodule

`default_nettype wire

//--- sim/tb_nco.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nco;
  import dds_pkg::*;

  localparam int  LUT_LAT    = 4;
  localparam int  NUM_BURSTS = 9;
  localparam real TWO_PI     = 6.283185307179586;

  // One row of the stimulus table
  typedef struct packed {
    phase_t fw;
    count_t n;
    logic   rand_ready;
    logic   restart;
    logic   same_as_prev;
  } burst_entry_t;

  logic   clk;
  logic   rst;
  phase_t freq_word;
  count_t num_samples;
  logic   start;
  logic   busy;
  iq_t    iq_data;
  logic   iq_valid;
  logic   iq_last;
  logic   iq_ready;

  burst_entry_t bursts [NUM_BURSTS];
  // Each beat is stored as {last, data}
  logic [32:0]  cur_seq [$];
  logic [32:0]  prev_seq [$];
  logic [31:0]  rng;
  int           value_errs;
  int           proto_errs;
  int           timeouts;

  nco_top #(.LUT_LAT(LUT_LAT)) i_dut (
    .clk         (clk),
    .rst         (rst),
    .freq_word   (freq_word),
    .num_samples (num_samples),
    .start       (start),
    .busy        (busy),
    .iq_data     (iq_data),
    .iq_valid    (iq_valid),
    .iq_last     (iq_last),
    .iq_ready    (iq_ready)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------

  task automatic load_table();
    // Zero word gives I = 16384 and Q = 0 throughout
    bursts[0] = '{fw: 24'h000000, n: 16'd6,  rand_ready: 0, restart: 0, same_as_prev: 0};
    // Steps straight across the quadrant boundaries
    bursts[1] = '{fw: 24'h400000, n: 16'd9,  rand_ready: 0, restart: 0, same_as_prev: 0};
    // Just under half a turn per sample
    bursts[2] = '{fw: 24'h7ff000, n: 16'd12, rand_ready: 0, restart: 0, same_as_prev: 0};
    bursts[3] = '{fw: 24'h7ff000, n: 16'd12, rand_ready: 1, restart: 0, same_as_prev: 1};
    bursts[4] = '{fw: 24'h012345, n: 16'd40, rand_ready: 0, restart: 0, same_as_prev: 0};
    bursts[5] = '{fw: 24'h012345, n: 16'd40, rand_ready: 1, restart: 0, same_as_prev: 1};
    // Second start lands mid-burst
    bursts[6] = '{fw: 24'h0a3d71, n: 16'd10, rand_ready: 0, restart: 1, same_as_prev: 0};
    bursts[7] = '{fw: 24'hc00000, n: 16'd5,  rand_ready: 1, restart: 1, same_as_prev: 0};
    // Zero length still yields one sample
    bursts[8] = '{fw: 24'h123456, n: 16'd0,  rand_ready: 0, restart: 0, same_as_prev: 0};
  endtask

  // ------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Nearest integer with halves rounded away from zero
  function automatic int round_real(input real r);
    if (r >= 0.0) begin
      return $rtoi(r + 0.5);
    end
    return -$rtoi(0.5 - r);
  endfunction

  task automatic check_close(input string name, input int exp_v, input int got_v);
    assert (got_v - exp_v <= 1 && exp_v - got_v <= 1) else begin
      value_errs++;
      $display("ERROR %0t: %s expected %0d, got %0d", $time, name, exp_v, got_v);
    end
  endtask

  // Sample k sits at k * fw on a 1024-point circle
  task automatic check_sample(input phase_t fw, input int k, input int total);
    logic [47:0] prod;
    logic [9:0]  top;
    real         ang;
    int          got_q;
    int          got_i;
    prod  = 48'(k) * 48'(fw);
    top   = prod[PHASE_W-1 -: 10];
    ang   = TWO_PI * $itor(top) / 1024.0;
    got_q = $signed(iq_data[31:16]);
    got_i = $signed(iq_data[15:0]);
    check_close($sformatf("iq_data[31:16] sample %0d", k),
                round_real(16384.0 * $sin(ang)), got_q);
    check_close($sformatf("iq_data[15:0] sample %0d", k),
                round_real(16384.0 * $cos(ang)), got_i);
    assert (iq_last == (k == total - 1)) else begin
      value_errs++;
      $display("ERROR %0t: iq_last sample %0d expected %0b, got %0b",
               $time, k, k == total - 1, iq_last);
    end
  endtask

  task automatic drive_ready(input logic rand_mode);
    if (rand_mode) begin
      rng      = xorshift32(rng);
      iq_ready = rng[0];
    end else begin
      iq_ready = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // Run and check one burst
  // ------------------------------------------------------------

  task automatic run_burst(input int b);
    burst_entry_t e;
    int           expected;
    int           got;
    int           cycles;
    int           idle;
    int           settle;
    int           limit;
    logic         seen_busy;
    logic         hold;
    iq_t          held_data;
    logic         held_last;
    e         = bursts[b];
    expected  = (e.n == '0) ? 1 : int'(e.n);
    limit     = 30 * expected + 20 * LUT_LAT + 50;
    got       = 0;
    cycles    = 0;
    idle      = 0;
    settle    = 0;
    seen_busy = 1'b0;
    hold      = 1'b0;
    cur_seq.delete();
    @(posedge clk);
    #1;
    freq_word   = e.fw;
    num_samples = e.n;
    start       = 1'b1;
    drive_ready(e.rand_ready);
    // Outputs are sampled at negedge and inputs driven 1 ns after posedge
    while (settle <= 2 * LUT_LAT && cycles < limit) begin
      @(negedge clk);
      if (hold) begin
        assert (iq_valid && iq_data == held_data && iq_last == held_last) else begin
          proto_errs++;
          $display("ERROR %0t: iq_data/iq_last moved under back-pressure, held %h/%b, now %h/%b",
                   $time, held_data, held_last, iq_data, iq_last);
        end
      end
      if (cycles < 2) begin
        assert (busy == (cycles == 1)) else begin
          proto_errs++;
          $display("ERROR %0t: busy expected %0b, got %0b", $time, cycles == 1, busy);
        end
      end
      // Beat transfers at the coming edge
      if (iq_valid && iq_ready) begin
        check_sample(e.fw, got, expected);
        cur_seq.push_back({iq_last, iq_data});
        got++;
      end
      hold      = iq_valid && !iq_ready;
      held_data = iq_data;
      held_last = iq_last;
      if (busy) begin
        seen_busy = 1'b1;
      end
      // Flush has to drain the core once input goes idle
      if (seen_busy && !busy && got < expected && !e.rand_ready) begin
        idle++;
        assert (idle <= 4 * LUT_LAT) else begin
          proto_errs++;
          $display("Burst %0d: %0d samples still stuck %0d cycles after the last phase",
                   b, expected - got, idle);
        end
        if (idle > 4 * LUT_LAT) begin
          break;
        end
      end
      if (seen_busy && !busy && got >= expected) begin
        settle++;
      end
      @(posedge clk);
      #1;
      start = e.restart && cycles == 3 && busy;
      if (start) begin
        freq_word   = e.fw ^ 24'h5a5a5a;
        num_samples = e.n + count_t'(7);
      end
      drive_ready(e.rand_ready);
      cycles++;
    end
    assert (cycles < limit) else begin
      timeouts++;
      $display("Timeout in burst %0d after %0d cycles with %0d of %0d outputs",
               b, cycles, got, expected);
    end
    assert (got == expected) else begin
      proto_errs++;
      $display("ERROR %0t: burst %0d output count expected %0d, got %0d",
               $time, b, expected, got);
    end
    // Random ready must give the same beats as ready held high
    if (e.same_as_prev) begin
      assert (cur_seq.size() == prev_seq.size()) else begin
        proto_errs++;
        $display("Burst %0d gave %0d beats under back-pressure, %0d without",
                 b, cur_seq.size(), prev_seq.size());
      end
      for (int i = 0; i < cur_seq.size() && i < prev_seq.size(); i++) begin
        assert (cur_seq[i] == prev_seq[i]) else begin
          value_errs++;
          $display("ERROR %0t: {iq_last,iq_data} beat %0d expected %h, got %h",
                   $time, i, prev_seq[i], cur_seq[i]);
        end
      end
    end
    prev_seq = cur_seq;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    freq_word   = '0;
    num_samples = '0;
    start       = 1'b0;
    iq_ready    = 1'b1;
    rng         = 32'hfce6_c8c4;
    value_errs  = 0;
    proto_errs  = 0;
    timeouts    = 0;
    load_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // Quiet outputs until the first start
    repeat (3) begin
      @(negedge clk);
      assert (!busy && !iq_valid && !iq_last) else begin
        proto_errs++;
        $display("ERROR %0t: busy/iq_valid/iq_last expected 0/0/0, got %b/%b/%b",
                 $time, busy, iq_valid, iq_last);
      end
    end
    for (int b = 0; b < NUM_BURSTS; b++) begin
      run_burst(b);
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/dds_pkg.sv
verilog/stream_if.sv
verilog/phase_burst_gen.sv
verilog/sincos_lut_pipe.sv
verilog/dds_flush_wrapper.sv
verilog/nco_top.sv
sim/tb_nco.sv

//--- Makefile
TOP := tb_nco
SIM := obj_dir/sim_nco

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -o sim_nco

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
